// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_sdma
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)

SOURCES := $(wildcard source/*.sv source/*.svh tb/*.sv)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "^TEST PASSED$$" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: filelist.f
+incdir+source
source/host_bus_pkg.sv
source/sample_pkg.sv
source/fsmc_slave.sv
source/adc_capture.sv
source/buffer_arbiter.sv
source/sample_ram.sv
source/sdma.sv
tb/tb_sdma.sv

// File: source/adc_capture.sv
`timescale 1ns/1ps
`include "sdma_params.svh"

module adc_capture (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  signal_in,
    input  sample_pkg::sample_t   adc_data,
    input  logic                  lock_set,
    input  logic                  lock_clr,
    output logic                  adc_clk,
    output logic                  adc_oe,
    output logic                  cap_we,
    output sample_pkg::buf_addr_t cap_addr,
    output sample_pkg::sample_t   cap_data,
    output logic                  ready,
    output sample_pkg::half_t     ready_half,
    output logic                  locked,
    output logic                  overrun
);
    import sample_pkg::*;

    localparam int HALF_DIV = `SDMA_ADC_DIV / 2;
    localparam int DIV_W    = (HALF_DIV > 1) ? $clog2(HALF_DIV) : 1;

    logic [DIV_W-1:0] div_cnt;
    logic             div_end;
    logic             adc_fall;
    logic             sig_q;
    logic             trig;
    logic             last;
    half_t            wr_half;
    buf_offset_t      wr_offset;

    // adc_clk toggles every HALF_DIV clk cycles
    assign div_end  = (div_cnt == DIV_W'(HALF_DIV - 1));
    // adc_clk goes low at this edge
    assign adc_fall = div_end & adc_clk;

    assign trig = signal_in & ~sig_q;
    assign last = (wr_offset == buf_offset_t'(`SDMA_BUF_DEPTH - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            div_cnt <= '0;
            adc_clk <= 1'b0;
        end else if (div_end) begin
            div_cnt <= '0;
            adc_clk <= ~adc_clk;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            sig_q      <= 1'b0;
            adc_oe     <= 1'b0;
            cap_we     <= 1'b0;
            wr_half    <= 1'b0;
            wr_offset  <= '0;
            ready      <= 1'b0;
            ready_half <= 1'b0;
            locked     <= 1'b0;
            overrun    <= 1'b0;
        end else begin
            sig_q  <= signal_in;
            // one write per sample
            cap_we <= adc_oe & adc_fall;
            if (lock_set) begin
                locked <= 1'b1;
            end
            // release also retires the finished half
            if (lock_clr) begin
                locked <= 1'b0;
                ready  <= 1'b0;
            end
            if (!adc_oe) begin
                // new block on a trigger edge
                if (trig) begin
                    adc_oe    <= 1'b1;
                    wr_offset <= '0;
                    overrun   <= 1'b0;
                end
            end else if (adc_fall) begin
                // triggers while busy fall through here
                wr_offset <= wr_offset + 1'b1;
                if (last) begin
                    adc_oe <= 1'b0;
                    if (locked && ready_half != wr_half) begin
                        // host still owns the other half
                        overrun <= 1'b1;
                    end else begin
                        ready      <= 1'b1;
                        ready_half <= wr_half;
                        wr_half    <= ~wr_half;
                    end
                end
            end
        end
    end

    // sample and address ride along with cap_we
    always_ff @(posedge clk) begin
        if (adc_oe && adc_fall) begin
            cap_addr <= '{half: wr_half, offset: wr_offset};
            cap_data <= adc_data;
        end
    end

endmodule

// File: source/buffer_arbiter.sv
`timescale 1ns/1ps

module buffer_arbiter (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  cap_we,
    input  sample_pkg::buf_addr_t cap_addr,
    input  sample_pkg::sample_t   cap_data,
    input  logic                  host_re,
    input  sample_pkg::buf_addr_t host_raddr,
    input  sample_pkg::sample_t   ram_rdata,
    output logic                  ram_en,
    output logic                  ram_we,
    output sample_pkg::buf_addr_t ram_addr,
    output sample_pkg::sample_t   ram_wdata,
    output logic                  host_rvalid,
    output sample_pkg::sample_t   host_rdata
);

    logic host_gnt;
    logic rd_pend;

    // capture always wins the port
    // host gets it in a free cycle with no read in flight
    assign host_gnt = host_re & ~cap_we & ~rd_pend;

    assign ram_en    = cap_we | host_gnt;
    assign ram_we    = cap_we;
    assign ram_addr  = cap_we ? cap_addr : host_raddr;
    assign ram_wdata = cap_data;

    // one read outstanding at most
    // ram answers the cycle after the grant
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_pend <= 1'b0;
        end else begin
            rd_pend <= host_gnt;
        end
    end

    assign host_rvalid = rd_pend;
    // ram keeps its output through write cycles
    assign host_rdata  = ram_rdata;

endmodule

// File: source/fsmc_slave.sv
`timescale 1ns/1ps
`include "sdma_params.svh"

module fsmc_slave (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     nadv,
    input  logic                     nwe,
    input  logic                     noe,
    input  host_bus_pkg::host_addr_t ad_in,
    output host_bus_pkg::host_data_t ad_out,
    output logic                     ad_oe,
    output logic                     host_re,
    output sample_pkg::buf_addr_t    host_raddr,
    input  logic                     host_rvalid,
    input  sample_pkg::sample_t      host_rdata,
    input  logic                     ready,
    input  sample_pkg::half_t        ready_half,
    input  logic                     locked,
    input  logic                     overrun,
    output logic                     lock_set,
    output logic                     lock_clr
);
    import host_bus_pkg::*;
    import sample_pkg::*;

    localparam int SYNC = `SDMA_SYNC_STAGES;

    // strobe shift chains
    // bit SYNC-1 is the synchronized level, bit SYNC the previous one
    logic [SYNC:0] nadv_sr;
    logic [SYNC:0] nwe_sr;
    logic [SYNC:0] noe_sr;

    // AD lines delayed to line up with the previous strobe bit
    host_addr_t ad_dly [SYNC+1];

    logic       nadv_rise;
    logic       nwe_rise;
    logic       noe_fall;
    logic       is_status;
    logic       wr_status;
    host_addr_t addr_q;
    host_data_t ad_out_q;
    status_t    st_word;
    logic       ovr_q;
    logic       ovr_flag;

    // edges on the synchronized strobes
    assign nadv_rise = nadv_sr[SYNC-1] & ~nadv_sr[SYNC];
    assign nwe_rise  = nwe_sr[SYNC-1] & ~nwe_sr[SYNC];
    assign noe_fall  = ~noe_sr[SYNC-1] & noe_sr[SYNC];

    assign is_status = (addr_q == host_addr_t'(`SDMA_STATUS_ADDR));

    // status writes turn into lock pulses
    // only bit 0 of the written word counts
    assign wr_status = nwe_rise & is_status;
    assign lock_set  = wr_status & ad_dly[SYNC][0];
    assign lock_clr  = wr_status & ~ad_dly[SYNC][0];

    // drive the pads for the whole synchronized read strobe
    assign ad_oe  = ~noe_sr[SYNC-1];
    assign ad_out = ad_out_q;

    always_comb begin
        st_word            = '0;
        st_word.ready      = ready;
        st_word.ready_half = ready_half;
        st_word.locked     = locked;
        st_word.overrun    = ovr_flag;
    end

    // strobes idle high
    always_ff @(posedge clk) begin
        if (rst) begin
            nadv_sr <= '1;
            nwe_sr  <= '1;
            noe_sr  <= '1;
        end else begin
            nadv_sr <= {nadv_sr[SYNC-1:0], nadv};
            nwe_sr  <= {nwe_sr[SYNC-1:0], nwe};
            noe_sr  <= {noe_sr[SYNC-1:0], noe};
        end
    end

    always_ff @(posedge clk) begin
        ad_dly[0] <= ad_in;
        for (int i = 1; i <= SYNC; i++) begin
            ad_dly[i] <= ad_dly[i-1];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            host_re  <= 1'b0;
            ovr_q    <= 1'b0;
            ovr_flag <= 1'b0;
        end else begin
            ovr_q <= overrun;
            // buffer read stays requested until the word comes back
            if (noe_fall && !is_status) begin
                host_re <= 1'b1;
            end else if (host_rvalid) begin
                host_re <= 1'b0;
            end
            // sticky until the host reads the status
            // a new drop wins over a clear in the same cycle
            if (overrun && !ovr_q) begin
                ovr_flag <= 1'b1;
            end else if (noe_fall && is_status) begin
                ovr_flag <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        // address phase ends on nadv rise
        if (nadv_rise) begin
            addr_q <= ad_dly[SYNC];
        end
        if (noe_fall) begin
            if (is_status) begin
                ad_out_q <= host_data_t'(st_word);
            end else begin
                // offset wraps at the half size
                host_raddr <= '{half: ready_half,
                                offset: addr_q[$bits(buf_offset_t)-1:0]};
            end
        end else if (host_rvalid && host_re) begin
            // held on the pads until the next read
            ad_out_q <= host_data_t'(host_rdata);
        end
    end

endmodule

// File: source/host_bus_pkg.sv
package host_bus_pkg;

    // multiplexed address as seen on the AD lines
    typedef logic [17:0] host_addr_t;

    // data word on the low AD lines
    typedef logic [15:0] host_data_t;

    // status word returned at the status address
    // msb first
    typedef struct packed {
        // a finished half waits for the host
        logic        ready;
        // which half is finished
        logic        ready_half;
        // host holds the finished half
        logic        locked;
        // a block was dropped since the last status read
        logic        overrun;
        logic [11:0] rsvd;
    } status_t;

endpackage

// File: source/sample_pkg.sv
`include "sdma_params.svh"

package sample_pkg;

    // one converter result
    typedef logic [11:0] sample_t;

    // ping-pong half select
    typedef logic half_t;

    // word offset inside one half
    typedef logic [$clog2(`SDMA_BUF_DEPTH)-1:0] buf_offset_t;

    // ram word address
    // half in the msb, offset below
    typedef struct packed {
        half_t       half;
        buf_offset_t offset;
    } buf_addr_t;

endpackage

// File: source/sample_ram.sv
`timescale 1ns/1ps
`include "sdma_params.svh"

module sample_ram (
    input  logic                  clk,
    input  logic                  ram_en,
    input  logic                  ram_we,
    input  sample_pkg::buf_addr_t ram_addr,
    input  sample_pkg::sample_t   ram_wdata,
    output sample_pkg::sample_t   ram_rdata
);
    import sample_pkg::*;

    // both ping-pong halves
    localparam int WORDS = 2 * `SDMA_BUF_DEPTH;

    sample_t mem [WORDS];

    // read data only moves on read cycles
    always_ff @(posedge clk) begin
        if (ram_en) begin
            if (ram_we) begin
                mem[ram_addr] <= ram_wdata;
            end else begin
                ram_rdata <= mem[ram_addr];
            end
        end
    end

endmodule

// File: source/sdma.sv
`timescale 1ns/1ps

module sdma (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     nadv,
    input  logic                     nwe,
    input  logic                     noe,
    input  host_bus_pkg::host_addr_t ad_in,
    output host_bus_pkg::host_data_t ad_out,
    output logic                     ad_oe,
    input  logic                     signal_in,
    input  sample_pkg::sample_t      adc_data,
    output logic                     adc_clk,
    output logic                     adc_oe
);
    import sample_pkg::*;

    // capture to arbiter
    logic      cap_we;
    buf_addr_t cap_addr;
    sample_t   cap_data;

    // bus slave to arbiter
    logic      host_re;
    buf_addr_t host_raddr;
    logic      host_rvalid;
    sample_t   host_rdata;

    // lock handshake pulses and status levels
    logic      lock_set;
    logic      lock_clr;
    logic      ready;
    half_t     ready_half;
    logic      locked;
    logic      overrun;

    // arbiter to ram
    logic      ram_en;
    logic      ram_we;
    buf_addr_t ram_addr;
    sample_t   ram_wdata;
    sample_t   ram_rdata;

    fsmc_slave fsmc_slave_inst (
        .clk         (clk),
        .rst         (rst),
        .nadv        (nadv),
        .nwe         (nwe),
        .noe         (noe),
        .ad_in       (ad_in),
        .ad_out      (ad_out),
        .ad_oe       (ad_oe),
        .host_re     (host_re),
        .host_raddr  (host_raddr),
        .host_rvalid (host_rvalid),
        .host_rdata  (host_rdata),
        .ready       (ready),
        .ready_half  (ready_half),
        .locked      (locked),
        .overrun     (overrun),
        .lock_set    (lock_set),
        .lock_clr    (lock_clr)
    );

    adc_capture adc_capture_inst (
        .clk        (clk),
        .rst        (rst),
        .signal_in  (signal_in),
        .adc_data   (adc_data),
        .lock_set   (lock_set),
        .lock_clr   (lock_clr),
        .adc_clk    (adc_clk),
        .adc_oe     (adc_oe),
        .cap_we     (cap_we),
        .cap_addr   (cap_addr),
        .cap_data   (cap_data),
        .ready      (ready),
        .ready_half (ready_half),
        .locked     (locked),
        .overrun    (overrun)
    );

    buffer_arbiter buffer_arbiter_inst (
        .clk         (clk),
        .rst         (rst),
        .cap_we      (cap_we),
        .cap_addr    (cap_addr),
        .cap_data    (cap_data),
        .host_re     (host_re),
        .host_raddr  (host_raddr),
        .ram_rdata   (ram_rdata),
        .ram_en      (ram_en),
        .ram_we      (ram_we),
        .ram_addr    (ram_addr),
        .ram_wdata   (ram_wdata),
        .host_rvalid (host_rvalid),
        .host_rdata  (host_rdata)
    );

    sample_ram sample_ram_inst (
        .clk       (clk),
        .ram_en    (ram_en),
        .ram_we    (ram_we),
        .ram_addr  (ram_addr),
        .ram_wdata (ram_wdata),
        .ram_rdata (ram_rdata)
    );

endmodule

// File: source/sdma_params.svh
`ifndef SDMA_PARAMS_SVH
`define SDMA_PARAMS_SVH

// samples per ping-pong half
`define SDMA_BUF_DEPTH 1024

// clk cycles per adc_clk period
// keep it even so both phases match
`define SDMA_ADC_DIV 4

// flops per bus strobe synchronizer
`define SDMA_SYNC_STAGES 2

// bus address of the status register
`define SDMA_STATUS_ADDR 16'h4000

`endif

// File: tb/sdma_stimulus.txt
# command arg1 arg2, numbers in hex
# test name | capture ofs | wait_ready | read addr exp | write addr data | dump ofs | dump_during ofs_ready ofs_new | end
test reset_state
read 4000 0000
test capture_readback
capture 000
wait_ready
read 4000 8000
dump 000
test ping_pong_contention
write 4000 0001
read 4000 a000
dump_during 000 100
read 4000 b000
read 4000 a000
test overrun
capture 200
read 4000 b000
read 4000 a000
read 0010 0010
test release_switch
write 4000 0000
read 4000 0000
capture 100
wait_ready
read 4000 c000
read 0005 0105
capture f80
wait_ready
read 4000 8000
dump f80
end

// File: tb/tb_sdma.sv
`timescale 1ns/1ps
`include "sdma_params.svh"

module tb_sdma;

    localparam int DEPTH = `SDMA_BUF_DEPTH;
    // cycle budgets per command
    localparam int unsigned CAP_BUDGET  = `SDMA_BUF_DEPTH * `SDMA_ADC_DIV + 50;
    localparam int unsigned RW_BUDGET   = 40;
    localparam int unsigned DUMP_BUDGET = `SDMA_BUF_DEPTH * 40;
    // one status poll takes about 20 cycles
    localparam int          MAX_POLLS   = CAP_BUDGET / 20;
    localparam logic [17:0] STATUS_ADDR = 18'(`SDMA_STATUS_ADDR);
    localparam logic [31:0] LFSR_MASK   = 32'ha300_0000;
    localparam logic [31:0] LFSR_SEED   = 32'd87975;
    // clk cycles in each adc_clk phase
    localparam int          ADC_PHASE   = `SDMA_ADC_DIV / 2;

    logic        clk = 1'b0;
    logic        rst;
    logic        nadv;
    logic        nwe;
    logic        noe;
    logic [17:0] ad_in;
    logic [15:0] ad_out;
    logic        ad_oe;
    logic        signal_in;
    logic [11:0] adc_data;
    logic        adc_clk;
    logic        adc_oe;

    // commands parsed from the stimulus file
    string       cmd_q[$];
    string       name_q[$];
    logic [31:0] arg1_q[$];
    logic [31:0] arg2_q[$];

    int unsigned cycle_cnt;
    int unsigned cycle_limit = 1000;
    logic [31:0] lfsr;
    logic [11:0] cap_offset;
    int          sample_idx;
    logic        adc_clk_q;
    logic        adc_oe_q;
    int          adc_run;
    bit          adc_clk_bad;
    int          check_cnt;
    int          pass_cnt;
    int          fail_cnt;
    int          test_checks;
    int          test_errors;
    string       cur_name;
    bit          load_ok;
    bit          saw_end;
    bit          stim_err;

    sdma sdma_inst (
        .clk       (clk),
        .rst       (rst),
        .nadv      (nadv),
        .nwe       (nwe),
        .noe       (noe),
        .ad_in     (ad_in),
        .ad_out    (ad_out),
        .ad_oe     (ad_oe),
        .signal_in (signal_in),
        .adc_data  (adc_data),
        .adc_clk   (adc_clk),
        .adc_oe    (adc_oe)
    );

    // 8 ns period
    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display("timeout: run did not finish within %0d clock cycles", cycle_limit);
            $display("TEST FAILED");
            $finish;
        end
    end

    // converter model driving an incrementing pattern from cap_offset
    initial begin
        adc_data    = '0;
        sample_idx  = 0;
        adc_clk_q   = 1'b0;
        adc_oe_q    = 1'b0;
        adc_run     = 0;
        adc_clk_bad = 1'b0;
        forever begin
            @(negedge clk);
            // adc_clk fell during a block so one sample was taken
            if (adc_oe_q && adc_clk_q && !adc_clk) begin
                sample_idx++;
            end
            if (!adc_oe) begin
                sample_idx = 0;
            end
            // length of the adc_clk phase that just ended
            if (adc_clk !== adc_clk_q) begin
                if (adc_oe && adc_run != ADC_PHASE) begin
                    adc_clk_bad = 1'b1;
                end
                adc_run = 1;
            end else begin
                adc_run++;
            end
            adc_data  = 12'((sample_idx + int'(cap_offset)) % 4096);
            adc_clk_q = adc_clk;
            adc_oe_q  = adc_oe;
        end
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ LFSR_MASK;
        end
        return state >> 1;
    endfunction

    function automatic int unsigned cmd_budget(input string cmd);
        if (cmd == "capture" || cmd == "wait_ready") begin
            return CAP_BUDGET;
        end else if (cmd == "read" || cmd == "write") begin
            return RW_BUDGET;
        end else if (cmd == "dump") begin
            return DUMP_BUDGET;
        end else if (cmd == "dump_during") begin
            return CAP_BUDGET + DUMP_BUDGET;
        end
        return 0;
    endfunction

    task automatic check_value(input string what, input logic [17:0] addr,
                               input logic [15:0] exp, input logic [15:0] got);
        check_cnt++;
        test_checks++;
        assert (got === exp) pass_cnt++;
        else begin
            fail_cnt++;
            test_errors++;
            $display("ERROR at %0t ns: %s addr %h expected %h read %h",
                     $time, what, addr, exp, got);
        end
    endtask

    task automatic check_true(input bit ok, input string msg);
        check_cnt++;
        test_checks++;
        assert (ok) pass_cnt++;
        else begin
            fail_cnt++;
            test_errors++;
            $display("ERROR at %0t ns: %s", $time, msg);
        end
    endtask

    task automatic finish_test();
        $display("test %s: %0d checks, %0d errors", cur_name, test_checks, test_errors);
        test_checks = 0;
        test_errors = 0;
    endtask

    // 3 lfsr bits give 0 to 7 idle cycles
    task automatic idle_gap();
        logic [2:0] gap;
        gap = '0;
        for (int b = 0; b < 3; b++) begin
            lfsr = lfsr_step(lfsr);
            gap  = {gap[1:0], lfsr[0]};
        end
        repeat (gap) @(negedge clk);
    endtask

    // every bus task starts and ends on a falling edge
    task automatic bus_write(input logic [17:0] addr, input logic [15:0] data);
        nadv  = 1'b0;
        ad_in = addr;
        repeat (8) @(negedge clk);
        // address stays on the lines one more edge
        nadv = 1'b1;
        @(negedge clk);
        ad_in = {2'b00, data};
        nwe   = 1'b0;
        repeat (8) @(negedge clk);
        nwe = 1'b1;
        @(negedge clk);
    endtask

    task automatic bus_read(input logic [17:0] addr, output logic [15:0] data);
        nadv  = 1'b0;
        ad_in = addr;
        repeat (8) @(negedge clk);
        nadv = 1'b1;
        @(negedge clk);
        noe = 1'b0;
        repeat (8) @(negedge clk);
        // last edge before the strobe goes back up
        check_true(ad_oe === 1'b1, "ad_oe was low while the host held noe low");
        data = ad_out;
        noe  = 1'b1;
        @(negedge clk);
    endtask

    task automatic capture_block(input logic [11:0] ofs);
        check_true(adc_oe === 1'b0, "adc_oe was already high before the trigger");
        adc_clk_bad = 1'b0;
        cap_offset  = ofs;
        signal_in   = 1'b1;
        @(negedge clk);
        signal_in = 1'b0;
        while (adc_oe !== 1'b1) begin
            @(negedge clk);
        end
        // block runs until adc_oe drops
        while (adc_oe !== 1'b0) begin
            @(negedge clk);
        end
        check_true(!adc_clk_bad, "adc_clk phases were not half the divider period long");
    endtask

    task automatic wait_for_ready();
        logic [15:0] st;
        int          polls;
        st    = '0;
        polls = 0;
        // bit 15 of the status word is ready
        while (!st[15] && polls < MAX_POLLS) begin
            bus_read(STATUS_ADDR, st);
            polls++;
        end
        check_true(st[15] === 1'b1, "status never showed a ready half");
    endtask

    task automatic dump_half(input logic [11:0] ofs);
        logic [15:0] got;
        logic [15:0] exp;
        for (int i = 0; i < DEPTH; i++) begin
            bus_read(18'(i), got);
            exp = 16'((int'(ofs) + i) % 4096);
            check_value("dump", 18'(i), exp, got);
        end
    endtask

    task automatic load_stimulus();
        int          fd;
        int          n;
        string       line;
        string       cmd;
        string       name;
        logic [31:0] a;
        logic [31:0] b;
        fd = $fopen("tb/sdma_stimulus.txt", "r");
        load_ok = (fd != 0);
        if (!load_ok) begin
            $display("could not open tb/sdma_stimulus.txt, no commands were run");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                cmd  = "";
                n = $fgets(line, fd);
                n = $sscanf(line, "%s", cmd);
                // blank lines and # comments are skipped
                if (n == 1 && cmd.getc(0) != "#") begin
                    name = "";
                    a    = '0;
                    b    = '0;
                    if (cmd == "test") begin
                        n = $sscanf(line, "%s %s", cmd, name);
                    end else begin
                        n = $sscanf(line, "%s %h %h", cmd, a, b);
                    end
                    cmd_q.push_back(cmd);
                    name_q.push_back(name);
                    arg1_q.push_back(a);
                    arg2_q.push_back(b);
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic run_commands();
        string       cmd;
        logic [31:0] a;
        logic [31:0] b;
        logic [15:0] got;
        for (int k = 0; k < cmd_q.size() && !saw_end; k++) begin
            cmd = cmd_q[k];
            a   = arg1_q[k];
            b   = arg2_q[k];
            if (cmd == "test") begin
                if (cur_name != "") begin
                    finish_test();
                end
                cur_name = name_q[k];
            end else if (cmd == "capture") begin
                capture_block(a[11:0]);
            end else if (cmd == "wait_ready") begin
                wait_for_ready();
            end else if (cmd == "read") begin
                bus_read(a[17:0], got);
                check_value("read", a[17:0], b[15:0], got);
            end else if (cmd == "write") begin
                bus_write(a[17:0], b[15:0]);
            end else if (cmd == "dump") begin
                dump_half(a[11:0]);
            end else if (cmd == "dump_during") begin
                // host reads the ready half while capture fills the other
                fork
                    capture_block(b[11:0]);
                    dump_half(a[11:0]);
                join
            end else if (cmd == "end") begin
                finish_test();
                saw_end = 1'b1;
            end else begin
                $display("unknown command %s in the stimulus file", cmd);
                stim_err = 1'b1;
            end
            if (!saw_end) begin
                idle_gap();
            end
        end
    endtask

    initial begin
        rst        = 1'b1;
        nadv       = 1'b1;
        nwe        = 1'b1;
        noe        = 1'b1;
        ad_in      = '0;
        signal_in  = 1'b0;
        cap_offset = '0;
        lfsr       = LFSR_SEED;
        cur_name   = "";
        load_stimulus();
        // budgets plus reset and idle gaps then doubled
        cycle_limit = 20;
        foreach (cmd_q[k]) begin
            cycle_limit += cmd_budget(cmd_q[k]) + 8;
        end
        cycle_limit = cycle_limit * 2;
        repeat (4) @(negedge clk);
        rst = 1'b0;
        check_true(adc_oe === 1'b0, "adc_oe was high after reset");
        check_true(ad_oe === 1'b0, "ad_oe was high after reset");
        if (load_ok) begin
            run_commands();
        end
        if (pass_cnt + fail_cnt != check_cnt) begin
            $display("some checks never ran their assertion, are assertions enabled");
        end
        if (!saw_end) begin
            $display("stimulus did not reach an end command");
        end
        $display("checks passed %0d failed %0d", pass_cnt, fail_cnt);
        if (load_ok && saw_end && !stim_err && fail_cnt == 0 && check_cnt > 0 &&
            pass_cnt == check_cnt) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
